// File: Makefile
# Verilator build for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# output goes to the console, the pass line decides the exit status
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/data_mem.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_settings.svh"

module data_mem (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     loader_active,  // loader owns the ram
    input  wire io_pkg::loader_wr_t loader,         // loader write port
    input  wire isa_pkg::mem_req_t  req,            // from ex/mem register

    output logic                    ram_en,
    output logic                    ram_we,
    output logic [`RAM_DEPTH-1:0]   ram_addr,       // word address
    output isa_pkg::word_t          ram_wdata,
    input  wire isa_pkg::word_t     ram_rdata,

    output logic                    input_take,     // keypad read, clears keypad
    input  wire isa_pkg::word_t     input_data,

    output logic                    vga_we,
    output isa_pkg::word_t          vga_data,

    output isa_pkg::word_t          read_data       // to mem/wb register
);
    import isa_pkg::*;
    import io_pkg::*;

    logic    io_page;   // addr in top 1 KB
    io_sel_t sel;       // decoded target
    logic    cpu_go;    // request may act
    logic    cpu_rd;
    logic    cpu_wr;
    io_sel_t rd_sel_q;  // target of last completed read
    word_t   key_q;     // keypad word captured on take

    // address decode
    assign io_page = (req.addr[`IO_START_BIT:`IO_END_BIT] == `IO_HIGH_ADDR);

    always_comb begin
        if (!io_page) begin
            sel = IO_RAM;
        end else if (req.addr[`IO_TYPE_BIT]) begin
            sel = IO_VGA;
        end else begin
            sel = IO_KEYPAD;
        end
    end

    assign cpu_go = ~req.no_op & ~loader_active;  // bubbles and loader mode kill cpu
    assign cpu_rd = cpu_go & req.read_en;
    assign cpu_wr = cpu_go & req.write_en;

    // ram port steering, loader wins while active
    always_comb begin
        if (loader_active) begin
            ram_en    = loader.we;
            ram_we    = loader.we;
            ram_addr  = loader.addr[`RAM_DEPTH+1:2];  // byte to word address
            ram_wdata = loader.data;
        end else begin
            ram_en    = (cpu_rd | cpu_wr) & (sel == IO_RAM);
            ram_we    = cpu_wr & (sel == IO_RAM);      // no ram write for io addresses
            ram_addr  = req.addr[`RAM_DEPTH+1:2];     // upper bits dropped, wraps
            ram_wdata = req.store_data;
        end
    end

    // io strobes
    assign input_take = cpu_rd & (sel == IO_KEYPAD);  // keypad writes ignored
    assign vga_we     = cpu_wr & (sel == IO_VGA);     // vga reads ignored
    assign vga_data   = req.store_data;

    // remember what the last read hit so data lines up with ram latency
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_sel_q <= IO_VGA;  // zero source until first read
        end else if (cpu_rd) begin
            rd_sel_q <= sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            key_q <= '0;
        end else if (input_take) begin
            key_q <= input_data;  // keypad clears on same edge
        end
    end

    // read data return mux
    always_comb begin
        case (rd_sel_q)
            IO_RAM:    read_data = ram_rdata;
            IO_KEYPAD: read_data = key_q;
            default:   read_data = '0;  // vga reads give zero
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_settings.svh"

module data_ram #(
    parameter int DEPTH = `RAM_DEPTH  // log2 of word count
) (
    input  wire                 clk,
    input  wire                 en,     // port enable
    input  wire                 we,     // write when enabled
    input  wire [DEPTH-1:0]     addr,   // word address
    input  wire isa_pkg::word_t wdata,
    output isa_pkg::word_t      rdata   // registered read word
);
    import isa_pkg::*;

    word_t mem [2**DEPTH];  // plain array, infers block ram

    // write first priority, read only when not writing
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];  // one cycle latency
            end
        end
        // en low keeps rdata as is
    end

endmodule

`default_nettype wire

// File: hdl/io_pkg.sv
`default_nettype none

`include "mem_settings.svh"

package io_pkg;

    // decoded target of a cpu access
    typedef enum logic [1:0] {
        IO_RAM    = 2'd0,  // data ram, default target
        IO_KEYPAD = 2'd1,  // keypad input port
        IO_VGA    = 2'd2   // vga output port
    } io_sel_t;

    // one write from the serial program loader
    typedef struct packed {
        logic                  we;    // write strobe
        logic [`ISA_WIDTH-1:0] addr;  // byte address
        logic [`ISA_WIDTH-1:0] data;  // word to store
    } loader_wr_t;

    // one keypad event
    typedef struct packed {
        logic valid;    // a bit key was pressed
        logic bit_val;  // 0 or 1 key
        logic clear;    // clear key
    } key_evt_t;

endpackage

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

`include "mem_settings.svh"

package isa_pkg;

    // one machine word
    typedef logic [`ISA_WIDTH-1:0] word_t;

    // request from ex/mem pipeline register
    typedef struct packed {
        word_t addr;        // byte address from alu
        word_t store_data;  // register value to store
        logic  read_en;     // load instruction
        logic  write_en;    // store instruction
        logic  no_op;       // bubble, kills both enables
    } mem_req_t;

endpackage

`default_nettype wire

// File: hdl/keypad_input.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_settings.svh"

module keypad_input (
    input  wire                   clk,
    input  wire                   rst,
    input  wire io_pkg::key_evt_t key,        // press or clear event
    input  wire                   take,       // cpu read of keypad port
    output isa_pkg::word_t        input_data  // binary word typed so far
);
    import isa_pkg::*;

    word_t word_q;  // entry register

    // binary entry, newest bit at lsb
    // take beats a press on the same cycle, press is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            word_q <= '0;
        end else if (take || key.clear) begin
            word_q <= '0;  // consumed by cpu or cleared by user
        end else if (key.valid) begin
            word_q <= {word_q[`ISA_WIDTH-2:0], key.bit_val};  // shift in pressed bit
        end
    end

    assign input_data = word_q;

endmodule

`default_nettype wire

// File: hdl/mem_stage_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_settings.svh"

module mem_stage_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     loader_active,  // program loader in control
    input  wire io_pkg::loader_wr_t loader,
    input  wire isa_pkg::mem_req_t  req,            // cpu memory request
    input  wire io_pkg::key_evt_t   key,            // keypad events
    output isa_pkg::word_t          read_data,      // load result
    output isa_pkg::word_t          display_word,   // vga word
    output logic [4:0]              scan_pos,
    output logic                    scan_bit
);
    import isa_pkg::*;

    // ram port
    logic                  ram_en;
    logic                  ram_we;
    logic [`RAM_DEPTH-1:0] ram_addr;
    word_t                 ram_wdata;
    word_t                 ram_rdata;

    // peripheral links
    logic  input_take;
    word_t input_data;
    logic  vga_we;
    word_t vga_data;

    data_mem u_data_mem (
        .clk           (clk),
        .rst           (rst),
        .loader_active (loader_active),
        .loader        (loader),
        .req           (req),
        .ram_en        (ram_en),
        .ram_we        (ram_we),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata),
        .input_take    (input_take),
        .input_data    (input_data),
        .vga_we        (vga_we),
        .vga_data      (vga_data),
        .read_data     (read_data)
    );

    data_ram #(.DEPTH(`RAM_DEPTH)) u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    keypad_input u_keypad_input (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .take       (input_take),
        .input_data (input_data)
    );

    vga_output u_vga_output (
        .clk          (clk),
        .rst          (rst),
        .we           (vga_we),
        .wdata        (vga_data),
        .display_word (display_word),
        .scan_pos     (scan_pos),
        .scan_bit     (scan_bit)
    );

endmodule

`default_nettype wire

// File: hdl/vga_output.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_settings.svh"

module vga_output (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 we,            // cpu store to vga port
    input  wire isa_pkg::word_t wdata,
    output isa_pkg::word_t      display_word,  // word on screen
    output logic [4:0]          scan_pos,      // bit being drawn
    output logic                scan_bit       // value of that bit
);
    import isa_pkg::*;

    word_t      disp_q;  // display register
    logic [4:0] pos_q;   // scan counter

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_q <= '0;
        end else if (we) begin
            disp_q <= wdata;  // new word shows next cycle
        end
    end

    // free running, wraps 31 -> 0 by width
    always_ff @(posedge clk) begin
        if (rst) begin
            pos_q <= '0;
        end else begin
            pos_q <= pos_q + 5'd1;
        end
    end

    assign display_word = disp_q;
    assign scan_pos     = pos_q;
    assign scan_bit     = disp_q[pos_q];  // display draws one bit per cycle

endmodule

`default_nettype wire

// File: include/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data path width
`define ISA_WIDTH 32

// log2 of ram word count, 16k words is 64 KB
`define RAM_DEPTH 14

// I/O page lives in the top 1 KB of the address space
`define IO_START_BIT 31
`define IO_END_BIT   10
`define IO_HIGH_ADDR 22'h3FFFFF

// picks keypad (0x..60) or vga (0x..70) inside the I/O page
`define IO_TYPE_BIT  4

`endif

// File: sim.f
+incdir+include
hdl/isa_pkg.sv
hdl/io_pkg.sv
hdl/data_ram.sv
hdl/data_mem.sv
hdl/keypad_input.sv
hdl/vga_output.sv
hdl/mem_stage_top.sv
tests/tb_mem_stage.sv

// File: tests/tb_mem_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_settings.svh"

module tb_mem_stage;
    import isa_pkg::*;
    import io_pkg::*;

    localparam int OP_LDR  = 0;  // loader write
    localparam int OP_WR   = 1;  // cpu write
    localparam int OP_RD   = 2;  // cpu read
    localparam int OP_KEY  = 3;  // key press, bit in data[0]
    localparam int OP_CLR  = 4;  // key clear
    localparam int OP_LWR  = 5;  // cpu write while loader active
    localparam int OP_IDLE = 6;  // nothing driven

    localparam int T_RAM = 0;
    localparam int T_KEY = 1;
    localparam int T_VGA = 2;

    localparam int MAX_ENT = 128;

    logic       clk = 1'b0;
    logic       rst;
    logic       loader_active;
    loader_wr_t loader;
    mem_req_t   req;
    key_evt_t   key;
    word_t      read_data;
    word_t      display_word;
    logic [4:0] scan_pos;
    logic       scan_bit;

    // stimulus table
    int          ops   [MAX_ENT];
    logic [31:0] addrs [MAX_ENT];
    logic [31:0] datas [MAX_ENT];
    logic        nops  [MAX_ENT];
    string       names [MAX_ENT];
    int          n_ent = 0;

    // reference model state
    logic [31:0] shadow [1 << `RAM_DEPTH];  // ram contents as the tb sees them
    logic [31:0] exp_rd;
    logic [31:0] exp_disp;
    logic [31:0] key_word;
    logic [4:0]  exp_pos;

    int pass_cnt = 0;
    int fail_cnt = 0;
    int grp_fail = 0;
    int cycles   = 0;
    int limit    = 1000;  // replaced once the table is built

    mem_stage_top uut (
        .clk           (clk),
        .rst           (rst),
        .loader_active (loader_active),
        .loader        (loader),
        .req           (req),
        .key           (key),
        .read_data     (read_data),
        .display_word  (display_word),
        .scan_pos      (scan_pos),
        .scan_bit      (scan_bit)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic add_entry(input int op, input logic [31:0] addr, input logic [31:0] data,
                             input logic nop, input string name);
        ops[n_ent]   = op;
        addrs[n_ent] = addr;
        datas[n_ent] = data;
        nops[n_ent]  = nop;
        names[n_ent] = name;
        n_ent        = n_ent + 1;
    endtask

    // decode by the address map rule
    function automatic int target_of(input logic [31:0] a);
        if (a[`IO_START_BIT:`IO_END_BIT] != `IO_HIGH_ADDR) return T_RAM;
        if (a[`IO_TYPE_BIT]) return T_VGA;
        return T_KEY;
    endfunction

    function automatic int word_idx(input logic [31:0] a);
        return int'(a[`RAM_DEPTH+1:2]);  // upper bits dropped
    endfunction

    task automatic clear_inputs();
        loader_active = 1'b0;
        loader        = '0;
        req           = '0;
        key           = '0;
    endtask

    task automatic drive_entry(input int i);
        clear_inputs();
        case (ops[i])
            OP_LDR: begin
                loader_active = 1'b1;
                loader.we     = 1'b1;
                loader.addr   = addrs[i];
                loader.data   = datas[i];
            end
            OP_WR, OP_LWR: begin
                loader_active  = (ops[i] == OP_LWR);  // loader idle but in control
                req.addr       = addrs[i];
                req.store_data = datas[i];
                req.write_en   = 1'b1;
                req.no_op      = nops[i];
            end
            OP_RD: begin
                req.addr    = addrs[i];
                req.read_en = 1'b1;
                req.no_op   = nops[i];
            end
            OP_KEY: begin
                key.valid   = 1'b1;
                key.bit_val = datas[i][0];
            end
            OP_CLR: key.clear = 1'b1;
            default: ;
        endcase
    endtask

    // state the dut should hold after this entry's edge
    task automatic apply_model(input int i);
        int tgt;
        tgt = target_of(addrs[i]);
        case (ops[i])
            OP_LDR: shadow[word_idx(addrs[i])] = datas[i];
            OP_WR: begin
                if (!nops[i] && tgt == T_RAM) shadow[word_idx(addrs[i])] = datas[i];
                if (!nops[i] && tgt == T_VGA) exp_disp = datas[i];  // keypad writes dropped
            end
            OP_RD: begin
                if (!nops[i] && tgt == T_RAM) exp_rd = shadow[word_idx(addrs[i])];
                if (!nops[i] && tgt == T_VGA) exp_rd = '0;
                if (!nops[i] && tgt == T_KEY) begin
                    exp_rd   = key_word;
                    key_word = '0;  // read consumes the entry
                end
            end
            OP_KEY: key_word = {key_word[30:0], datas[i][0]};
            OP_CLR: key_word = '0;
            default: ;  // loader-mode cpu writes and idle change nothing
        endcase
    endtask

    task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %0t ns %s expected %h actual %h", $time, sig, exp, act);
            fail_cnt = fail_cnt + 1;
            grp_fail = grp_fail + 1;
        end else begin
            pass_cnt = pass_cnt + 1;
        end
    endtask

    task automatic build_table();
        logic [31:0] ld_addr [8];
        for (int k = 0; k < 8; k++) begin
            ld_addr[k] = ($urandom % (1 << `RAM_DEPTH)) << 2;  // random aligned ram word
            add_entry(OP_LDR, ld_addr[k], $urandom, 1'b0, "loader load");
        end
        for (int k = 0; k < 8; k++) begin
            add_entry(OP_RD, ld_addr[k], 32'h0, 1'b0, "loader load");  // back to back
        end
        add_entry(OP_LWR, ld_addr[0], 32'hDEAD_BEEF, 1'b0, "loader blocks cpu");
        add_entry(OP_LWR, 32'hFFFF_FC70, 32'hBAD0_0001, 1'b0, "loader blocks cpu");
        add_entry(OP_RD, ld_addr[0], 32'h0, 1'b0, "loader blocks cpu");
        add_entry(OP_WR, 32'h0000_0400, 32'h1234_5678, 1'b0, "write read");
        add_entry(OP_RD, 32'h0000_0400, 32'h0, 1'b0, "write read");
        add_entry(OP_WR, 32'h0000_0400, 32'h8765_4321, 1'b1, "write read");  // bubble
        add_entry(OP_RD, 32'h0000_0400, 32'h0, 1'b0, "write read");
        add_entry(OP_RD, 32'h0000_0800, 32'h0, 1'b1, "write read");  // bubble read
        add_entry(OP_WR, 32'h0000_FC70, 32'h0F0F_1234, 1'b0, "vga port");  // same low bits
        add_entry(OP_WR, 32'hFFFF_FC70, $urandom, 1'b0, "vga port");
        add_entry(OP_RD, 32'hFFFF_FC70, 32'h0, 1'b0, "vga port");
        add_entry(OP_RD, 32'h0000_FC70, 32'h0, 1'b0, "vga port");
        for (int k = 0; k < 32; k++) begin
            add_entry(OP_IDLE, 32'h0, 32'h0, 1'b0, "vga port");  // full scan sweep
        end
        add_entry(OP_KEY, 32'h0, 32'h1, 1'b0, "keypad");
        add_entry(OP_KEY, 32'h0, 32'h0, 1'b0, "keypad");
        add_entry(OP_KEY, 32'h0, 32'h1, 1'b0, "keypad");
        add_entry(OP_KEY, 32'h0, 32'h1, 1'b0, "keypad");
        add_entry(OP_WR, 32'hFFFF_FC60, 32'h5555_5555, 1'b0, "keypad");  // must not clear entry
        add_entry(OP_RD, 32'hFFFF_FC60, 32'h0, 1'b0, "keypad");
        add_entry(OP_RD, 32'hFFFF_FC60, 32'h0, 1'b0, "keypad");  // emptied by first read
        add_entry(OP_KEY, 32'h0, 32'h1, 1'b0, "keypad");
        add_entry(OP_KEY, 32'h0, 32'h1, 1'b0, "keypad");
        add_entry(OP_CLR, 32'h0, 32'h0, 1'b0, "keypad");
        add_entry(OP_RD, 32'hFFFF_FC60, 32'h0, 1'b0, "keypad");
        add_entry(OP_WR, 32'h0001_0040, $urandom, 1'b0, "address wrap");
        add_entry(OP_RD, 32'h0000_0040, 32'h0, 1'b0, "address wrap");
        add_entry(OP_WR, 32'h8000_0084, $urandom, 1'b0, "address wrap");
        add_entry(OP_RD, 32'h0001_0084, 32'h0, 1'b0, "address wrap");
    endtask

    initial begin
        int seed;
        seed = $urandom(22);
        rst = 1'b1;
        clear_inputs();
        exp_rd   = '0;
        exp_disp = '0;
        key_word = '0;
        exp_pos  = '0;
        build_table();
        limit = 16 + 2 * n_ent + 64;
        repeat (16) @(negedge clk);
        rst = 1'b0;  // scan counter starts at zero here

        for (int i = 0; i <= n_ent; i++) begin
            @(negedge clk);
            exp_pos = exp_pos + 5'd1;
            if (i > 0) begin
                check_val("read_data", exp_rd, read_data);
                check_val("display_word", exp_disp, display_word);
                check_val("scan_pos", {27'b0, exp_pos}, {27'b0, scan_pos});
                check_val("scan_bit", {31'b0, exp_disp[exp_pos]}, {31'b0, scan_bit});
                if (i == n_ent || names[i] != names[i-1]) begin
                    if (grp_fail == 0) begin
                        $display("test %s: ok", names[i-1]);
                    end else begin
                        $display("test %s: %0d wrong values", names[i-1], grp_fail);
                    end
                    grp_fail = 0;
                end
            end
            if (i < n_ent) begin
                drive_entry(i);
                apply_model(i);
            end else begin
                clear_inputs();
            end
        end

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
